//--- Makefile
VERILATOR ?= verilator
TOP       ?= matrixTb
FILELIST  ?= hub75Matrix.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= No errors

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- hub75Matrix.f
logic/hub75Pkg.sv
logic/panelInit.sv
logic/frameBuffer.sv
logic/brightnessReg.sv
logic/rowScanner.sv
logic/matrixTop.sv
tests/matrixChecker.sv
tests/matrixTb.sv

//--- logic/brightnessReg.sv
`timescale 1ns/1ns

module brightnessReg (
    input  logic                                   clk_in,
    input  logic                                   reset,
    input  logic                                   brightWrEn,
    input  logic [hub75Pkg::colorBits-1:0]         brightValue,
    input  logic                                   planeStart,
    input  logic [$clog2(hub75Pkg::colorBits)-1:0] planeIndex,
    output logic                                   oeActive
);
    import hub75Pkg::*;

    // longest window is 2^colorBits shifted by the top plane
    localparam int countBits = 2 * colorBits;

    logic [colorBits-1:0] brightLevel;
    logic [countBits-1:0] windowCount;
    logic [countBits-1:0] windowLength;

    // level+1 cycles on plane 0, doubling for each higher plane
    assign windowLength = (countBits'(brightLevel) + 1'b1) << planeIndex;

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            // full brightness out of reset
            brightLevel <= '1;
            windowCount <= '0;
        end else begin
            if (brightWrEn) begin
                brightLevel <= brightValue;
            end
            // a new level only shows up on the next window load
            if (planeStart) begin
                windowCount <= windowLength;
            end else if (windowCount != '0) begin
                windowCount <= windowCount - 1'b1;
            end
        end
    end

    // high for exactly windowLength cycles after planeStart
    assign oeActive = (windowCount != '0);

endmodule

//--- logic/frameBuffer.sv
`timescale 1ns/1ns

module frameBuffer #(
    parameter int panelWidth = 64
) (
    input  logic                                   clk_in,
    input  logic                                   wrEn,
    input  logic [$clog2(panelWidth)-1:0]          wrX,
    input  logic [$clog2(hub75Pkg::panelRows)-1:0] wrY,
    input  logic [hub75Pkg::pixelWord-1:0]         wrColor,
    input  logic [$clog2(panelWidth)-1:0]          rdAddr,
    input  logic [hub75Pkg::rowAddrBits-1:0]       rdRow,
    output logic [hub75Pkg::pixelWord-1:0]         rdUpper,
    output logic [hub75Pkg::pixelWord-1:0]         rdLower
);
    import hub75Pkg::*;

    localparam int depth = scanRows * panelWidth;

    // one bank per half panel, same index reads row r and r+16
    logic [pixelWord-1:0]     upperMem [depth];
    logic [pixelWord-1:0]     lowerMem [depth];
    logic [$clog2(depth)-1:0] wrIndex;
    logic [$clog2(depth)-1:0] rdIndex;

    // top bit of wrY picks the bank
    assign wrIndex = {wrY[rowAddrBits-1:0], wrX};
    assign rdIndex = {rdRow, rdAddr};

    always_ff @(posedge clk_in) begin
        if (wrEn && !wrY[rowAddrBits]) begin
            upperMem[wrIndex] <= wrColor;
        end
        if (wrEn && wrY[rowAddrBits]) begin
            lowerMem[wrIndex] <= wrColor;
        end
        // registered read, one cycle latency
        rdUpper <= upperMem[rdIndex];
        rdLower <= lowerMem[rdIndex];
    end

endmodule

//--- logic/hub75Pkg.sv
package hub75Pkg;

    ////////////////////////////////////////////////////////////
    // panel geometry
    ////////////////////////////////////////////////////////////

    // pixels on one row of a single panel
    localparam int panelWidth = 64;
    // rows per half panel, one row address value each
    localparam int scanRows = 16;
    // upper and lower half together
    localparam int panelRows = 2 * scanRows;
    localparam int rowAddrBits = $clog2(scanRows);

    // bits per colour channel, one bit plane each
    localparam int colorBits = 4;
    // host word packs red, green, blue from the top
    localparam int pixelWord = 3 * colorBits;

    ////////////////////////////////////////////////////////////
    // FM6126A configuration
    ////////////////////////////////////////////////////////////

    // register 12, all bits set except bit 0
    localparam logic [15:0] initReg12 = 16'hfffe;
    // register 13, only bit 9 set
    localparam logic [15:0] initReg13 = 16'h0200;
    // trailing pixels of each pass that carry latch
    localparam int latchLen12 = 12;
    localparam int latchLen13 = 13;

endpackage

//--- logic/matrixTop.sv
`timescale 1ns/1ns

module matrixTop #(
    parameter int panelWidth = hub75Pkg::panelWidth
) (
    input  logic                                   clk_in,
    input  logic                                   reset,
    input  logic                                   wrEn,
    input  logic [$clog2(panelWidth)-1:0]          wrX,
    input  logic [$clog2(hub75Pkg::panelRows)-1:0] wrY,
    input  logic [hub75Pkg::pixelWord-1:0]         wrColor,
    input  logic                                   brightWrEn,
    input  logic [hub75Pkg::colorBits-1:0]         brightValue,
    output logic [2:0]                             rgb1,
    output logic [2:0]                             rgb2,
    output logic [hub75Pkg::rowAddrBits-1:0]       rowAddr,
    output logic                                   latch,
    output logic                                   panelOe,
    output logic                                   pixClk,
    output logic                                   initDone
);
    import hub75Pkg::*;

    // init sequencer to scanner
    logic [2:0] initRgb1;
    logic [2:0] initRgb2;
    logic       initLatch;
    logic       initOe;
    logic       initPixClk;

    // scanner read port
    logic [$clog2(panelWidth)-1:0] rdAddr;
    logic [rowAddrBits-1:0]        rdRow;
    logic [pixelWord-1:0]          rdUpper;
    logic [pixelWord-1:0]          rdLower;

    // brightness window handshake-free pulse and level
    logic                         planeStart;
    logic [$clog2(colorBits)-1:0] planeIndex;
    logic                         oeActive;

    panelInit #(
        .panelWidth(panelWidth)
    ) panelInit_inst (
        .clk_in,
        .reset,
        .initRgb1,
        .initRgb2,
        .initLatch,
        .initOe,
        .initPixClk,
        .initDone
    );

    frameBuffer #(
        .panelWidth(panelWidth)
    ) frameBuffer_inst (
        .clk_in,
        .wrEn,
        .wrX,
        .wrY,
        .wrColor,
        .rdAddr,
        .rdRow,
        .rdUpper,
        .rdLower
    );

    brightnessReg brightnessReg_inst (
        .clk_in,
        .reset,
        .brightWrEn,
        .brightValue,
        .planeStart,
        .planeIndex,
        .oeActive
    );

    rowScanner #(
        .panelWidth(panelWidth)
    ) rowScanner_inst (
        .clk_in,
        .reset,
        .initRgb1,
        .initRgb2,
        .initLatch,
        .initOe,
        .initPixClk,
        .initDone,
        .rdAddr,
        .rdRow,
        .rdUpper,
        .rdLower,
        .planeStart,
        .planeIndex,
        .oeActive,
        .rgb1,
        .rgb2,
        .rowAddr,
        .latch,
        .panelOe,
        .pixClk
    );

endmodule

//--- logic/panelInit.sv
`timescale 1ns/1ns

module panelInit #(
    parameter int panelWidth = 64
) (
    input  logic       clk_in,
    input  logic       reset,
    output logic [2:0] initRgb1,
    output logic [2:0] initRgb2,
    output logic       initLatch,
    output logic       initOe,
    output logic       initPixClk,
    output logic       initDone
);
    import hub75Pkg::*;

    localparam int countBits = $clog2(panelWidth);

    // one-hot sequence, one load/clock pair per register
    localparam logic [5:0] stateIdle   = 6'b000001,
                           stateLoad12 = 6'b000010,
                           stateClk12  = 6'b000100,
                           stateLoad13 = 6'b001000,
                           stateClk13  = 6'b010000,
                           stateFinish = 6'b100000;

    logic [5:0]            state;
    logic [countBits-1:0]  pixelCount;
    // ones drain out one per pixel, latch once it is empty
    logic [panelWidth-1:0] latchWindow;
    logic                  patternBit;
    logic                  lastPixel;

    // register pattern repeats every 16 pixels across the row
    assign patternBit = (state == stateLoad13) ? initReg13[pixelCount[3:0]]
                                               : initReg12[pixelCount[3:0]];
    assign lastPixel  = (pixelCount == countBits'(panelWidth - 1));

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state       <= stateIdle;
            pixelCount  <= '0;
            latchWindow <= '0;
            initRgb1    <= 3'b000;
            initRgb2    <= 3'b000;
            initLatch   <= 1'b0;
            initOe      <= 1'b1;
            initPixClk  <= 1'b0;
            initDone    <= 1'b0;
        end else begin
            case (state)
                stateIdle: begin
                    pixelCount  <= '0;
                    // leaves panelWidth-12 ones, so the last 12 pixels latch
                    latchWindow <= {panelWidth{1'b1}} >> latchLen12;
                    state       <= stateLoad12;
                end
                stateLoad12, stateLoad13: begin
                    // data and latch settle while the pixel clock is low
                    initPixClk <= 1'b0;
                    initLatch  <= ~(|latchWindow);
                    initRgb1   <= {3{patternBit}};
                    initRgb2   <= {3{patternBit}};
                    state      <= (state == stateLoad12) ? stateClk12 : stateClk13;
                end
                stateClk12: begin
                    initPixClk <= 1'b1;
                    // counter wraps to zero for the second pass
                    pixelCount <= pixelCount + 1'b1;
                    if (lastPixel) begin
                        latchWindow <= {panelWidth{1'b1}} >> latchLen13;
                        state       <= stateLoad13;
                    end else begin
                        latchWindow <= latchWindow >> 1;
                        state       <= stateLoad12;
                    end
                end
                stateClk13: begin
                    initPixClk  <= 1'b1;
                    pixelCount  <= pixelCount + 1'b1;
                    latchWindow <= latchWindow >> 1;
                    state       <= lastPixel ? stateFinish : stateLoad13;
                end
                stateFinish: begin
                    // park the pins, display stays blanked
                    initPixClk <= 1'b0;
                    initLatch  <= 1'b0;
                    initRgb1   <= 3'b000;
                    initRgb2   <= 3'b000;
                    initOe     <= 1'b1;
                    initDone   <= 1'b1;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

endmodule

//--- logic/rowScanner.sv
`timescale 1ns/1ns

module rowScanner #(
    parameter int panelWidth = 64
) (
    input  logic                                   clk_in,
    input  logic                                   reset,
    input  logic [2:0]                             initRgb1,
    input  logic [2:0]                             initRgb2,
    input  logic                                   initLatch,
    input  logic                                   initOe,
    input  logic                                   initPixClk,
    input  logic                                   initDone,
    output logic [$clog2(panelWidth)-1:0]          rdAddr,
    output logic [hub75Pkg::rowAddrBits-1:0]       rdRow,
    input  logic [hub75Pkg::pixelWord-1:0]         rdUpper,
    input  logic [hub75Pkg::pixelWord-1:0]         rdLower,
    output logic                                   planeStart,
    output logic [$clog2(hub75Pkg::colorBits)-1:0] planeIndex,
    input  logic                                   oeActive,
    output logic [2:0]                             rgb1,
    output logic [2:0]                             rgb2,
    output logic [hub75Pkg::rowAddrBits-1:0]       rowAddr,
    output logic                                   latch,
    output logic                                   panelOe,
    output logic                                   pixClk
);
    import hub75Pkg::*;

    localparam int pixBits   = $clog2(panelWidth);
    localparam int planeBits = $clog2(colorBits);
    localparam logic [planeBits-1:0] topPlane = planeBits'(colorBits - 1);

    localparam logic [2:0] stateIdle  = 3'd0,
                           statePrep  = 3'd1,
                           stateLow   = 3'd2,
                           stateHigh  = 3'd3,
                           stateWait  = 3'd4,
                           stateLatch = 3'd5;

    logic [2:0]             state;
    logic [pixBits-1:0]     pixelCount;
    logic [planeBits-1:0]   plane;
    logic [rowAddrBits-1:0] scanRow;
    // row currently latched and shown on the panel
    logic [rowAddrBits-1:0] shownRow;
    logic                   scanLatch;
    logic                   scanPixClk;
    logic [2:0]             scanRgb1;
    logic [2:0]             scanRgb2;

    // bit p of each channel, packed as {r, g, b}
    function automatic logic [2:0] planeSlice(input logic [pixelWord-1:0] color,
                                              input logic [planeBits-1:0] p);
        logic [colorBits-1:0] red;
        logic [colorBits-1:0] green;
        logic [colorBits-1:0] blue;
        {red, green, blue} = color;
        return {red[p], green[p], blue[p]};
    endfunction

    ////////////////////////////////////////////////////////////
    // frame buffer fetch
    ////////////////////////////////////////////////////////////

    // look one pixel ahead in the high phase to cover read latency
    assign rdAddr = (state == stateHigh) ? pixelCount + 1'b1 : pixelCount;
    assign rdRow  = scanRow;

    // window for the plane just latched
    assign planeStart = (state == stateLatch);
    assign planeIndex = plane;

    ////////////////////////////////////////////////////////////
    // shift, latch and display sequence
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state      <= stateIdle;
            pixelCount <= '0;
            plane      <= topPlane;
            scanRow    <= '0;
            shownRow   <= '0;
            scanLatch  <= 1'b0;
            scanPixClk <= 1'b0;
            scanRgb1   <= 3'b000;
            scanRgb2   <= 3'b000;
        end else begin
            case (state)
                stateIdle: begin
                    // init sequencer owns the pins until done
                    if (initDone) begin
                        state <= statePrep;
                    end
                end
                statePrep: begin
                    // pixel 0 address of the new row is in flight
                    state <= stateLow;
                end
                stateLow: begin
                    scanPixClk <= 1'b0;
                    scanRgb1   <= planeSlice(rdUpper, plane);
                    scanRgb2   <= planeSlice(rdLower, plane);
                    state      <= stateHigh;
                end
                stateHigh: begin
                    scanPixClk <= 1'b1;
                    pixelCount <= pixelCount + 1'b1;
                    if (pixelCount == pixBits'(panelWidth - 1)) begin
                        state <= stateWait;
                    end else begin
                        state <= stateLow;
                    end
                end
                stateWait: begin
                    scanPixClk <= 1'b0;
                    // previous plane may still be lit
                    if (!oeActive) begin
                        shownRow  <= scanRow;
                        scanLatch <= 1'b1;
                        state     <= stateLatch;
                    end
                end
                stateLatch: begin
                    scanLatch <= 1'b0;
                    // planes high to low, then on to the next row
                    if (plane == '0) begin
                        plane   <= topPlane;
                        scanRow <= scanRow + 1'b1;
                    end else begin
                        plane <= plane - 1'b1;
                    end
                    state <= statePrep;
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // panel pins
    ////////////////////////////////////////////////////////////

    assign rgb1    = initDone ? scanRgb1 : initRgb1;
    assign rgb2    = initDone ? scanRgb2 : initRgb2;
    assign latch   = initDone ? scanLatch : initLatch;
    assign pixClk  = initDone ? scanPixClk : initPixClk;
    // blank except during the brightness window
    assign panelOe = initDone ? ~oeActive : initOe;
    assign rowAddr = shownRow;

endmodule

//--- tests/matrixChecker.sv
`timescale 1ns/1ns

module matrixChecker #(
    parameter int panelWidth = hub75Pkg::panelWidth
) (
    input  logic                                   clk_in,
    input  logic                                   reset,
    input  logic                                   wrEn,
    input  logic [$clog2(panelWidth)-1:0]          wrX,
    input  logic [$clog2(hub75Pkg::panelRows)-1:0] wrY,
    input  logic [hub75Pkg::pixelWord-1:0]         wrColor,
    input  logic [2:0]                             rgb1,
    input  logic [2:0]                             rgb2,
    input  logic [hub75Pkg::rowAddrBits-1:0]       rowAddr,
    input  logic                                   latch,
    input  logic                                   panelOe,
    input  logic                                   pixClk,
    input  logic                                   initDone,
    input  logic                                   arm,
    input  int                                     windowBase,
    output int                                     initPixels,
    output int                                     frameCount,
    output int                                     checkCount,
    output int                                     windowChecks,
    output int                                     initErrors,
    output int                                     doneErrors,
    output int                                     dataErrors,
    output int                                     orderErrors,
    output int                                     windowErrors
);
    import hub75Pkg::*;

    // own copy of the frame, fed by the host write strobes
    logic [pixelWord-1:0] model [panelRows][panelWidth];

    // pin values from the previous sample, for edge detection
    logic prevPixClk;
    logic prevLatch;
    logic prevOe;

    logic sawDone;
    // data and window checks run only between two arms
    logic active;
    logic measuring;
    int   pixIndex;
    int   plane;
    int   row;
    int   lowCycles;
    int   expWindow;

    // red, green, blue from the top of the host word, bit p of each
    function automatic logic [2:0] expectBits(input logic [pixelWord-1:0] color, input int p);
        return {color[2 * colorBits + p], color[colorBits + p], color[p]};
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual,
                              inout int errors);
        checkCount++;
        if (expected != actual) begin
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // pins sampled on the system clock, where they are stable
    ////////////////////////////////////////////////////////////

    always @(posedge clk_in or posedge reset) begin
        int   n;
        logic firstPass;
        logic bitVal;
        logic expLatch;
        if (reset) begin
            prevPixClk   = 1'b0;
            prevLatch    = 1'b0;
            prevOe       = 1'b1;
            sawDone      = 1'b0;
            active       = 1'b0;
            measuring    = 1'b0;
            pixIndex     = 0;
            plane        = colorBits - 1;
            row          = 0;
            lowCycles    = 0;
            expWindow    = 0;
            initPixels   = 0;
            frameCount   = 0;
            checkCount   = 0;
            windowChecks = 0;
            initErrors   = 0;
            doneErrors   = 0;
            dataErrors   = 0;
            orderErrors  = 0;
            windowErrors = 0;
        end else begin
            if (!initDone) begin
                if (sawDone) begin
                    $display("initDone fell at %0t after init had finished", $time);
                    doneErrors++;
                end
                // display stays blanked during configuration
                checkValue("panelOe", 1, int'(panelOe), doneErrors);
                if (pixClk && !prevPixClk) begin
                    // register 12 on the first pass, 13 on the second
                    n         = initPixels % panelWidth;
                    firstPass = (initPixels < panelWidth);
                    bitVal    = firstPass ? initReg12[n % 16] : initReg13[n % 16];
                    expLatch  = (n >= panelWidth - (firstPass ? latchLen12 : latchLen13));
                    checkValue("rgb1", int'({3{bitVal}}), int'(rgb1), initErrors);
                    checkValue("rgb2", int'({3{bitVal}}), int'(rgb2), initErrors);
                    checkValue("latch", int'(expLatch), int'(latch), initErrors);
                    initPixels++;
                end
            end else begin
                sawDone = 1'b1;
                if (!arm) begin
                    active    = 1'b0;
                    measuring = 1'b0;
                end
                // shifted pixel, upper row on rgb1 and row+16 on rgb2
                if (pixClk && !prevPixClk) begin
                    if (active && pixIndex < panelWidth) begin
                        checkValue("rgb1", int'(expectBits(model[row][pixIndex], plane)),
                                   int'(rgb1), dataErrors);
                        checkValue("rgb2",
                                   int'(expectBits(model[row + scanRows][pixIndex], plane)),
                                   int'(rgb2), dataErrors);
                    end
                    pixIndex++;
                end
                // low time of output enable after the plane latch
                if (measuring) begin
                    if (!panelOe) begin
                        lowCycles++;
                    end else if (!prevOe) begin
                        checkValue("panelOe low cycles", expWindow, lowCycles, windowErrors);
                        windowChecks++;
                        measuring = 1'b0;
                    end
                end
                if (latch && !prevLatch) begin
                    if (active) begin
                        checkValue("pixel count", panelWidth, pixIndex, orderErrors);
                        checkValue("rowAddr", row, int'(rowAddr), orderErrors);
                    end
                    if (arm) begin
                        active    = 1'b1;
                        measuring = 1'b1;
                        lowCycles = 0;
                        expWindow = windowBase << plane;
                    end
                    pixIndex = 0;
                    // planes high to low, then the next row
                    if (plane == 0) begin
                        plane = colorBits - 1;
                        row   = (row + 1) % scanRows;
                        if (row == 0 && active) begin
                            frameCount++;
                        end
                    end else begin
                        plane--;
                    end
                end
            end
            // write lands at this edge, after the compares above
            if (wrEn) begin
                model[wrY][wrX] = wrColor;
            end
            prevPixClk = pixClk;
            prevLatch  = latch;
            prevOe     = panelOe;
        end
    end

endmodule

//--- tests/matrixTb.sv
`timescale 1ns/1ns

module matrixTb;
    import hub75Pkg::*;

    localparam int xBits      = $clog2(panelWidth);
    localparam int yBits      = $clog2(panelRows);
    localparam int tableLen   = 6;
    // cycle limits for each wait
    localparam int initLimit  = 4 * panelWidth + 100;
    localparam int frameLimit = 12000;

    logic                   clk_in = 1'b0;
    logic                   reset;
    logic                   wrEn;
    logic [xBits-1:0]       wrX;
    logic [yBits-1:0]       wrY;
    logic [pixelWord-1:0]   wrColor;
    logic                   brightWrEn;
    logic [colorBits-1:0]   brightValue;
    logic [2:0]             rgb1;
    logic [2:0]             rgb2;
    logic [rowAddrBits-1:0] rowAddr;
    logic                   latch;
    logic                   panelOe;
    logic                   pixClk;
    logic                   initDone;

    // checker control and results
    logic arm;
    int   windowBase;
    int   initPixels;
    int   frameCount;
    int   checkCount;
    int   windowChecks;
    int   initErrors;
    int   doneErrors;
    int   dataErrors;
    int   orderErrors;
    int   windowErrors;
    int   tbErrors;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    // brightness value and its plane 0 window, value plus one
    logic [colorBits-1:0] tableBright [tableLen] = '{4'd0, 4'd3, 4'd7, 4'd15, 4'd9, 4'd1};
    int                   tableWindow [tableLen] = '{1, 4, 8, 16, 10, 2};
    // pixel writes, filled from the LCG
    logic [xBits-1:0]     tableX [tableLen];
    logic [yBits-1:0]     tableY [tableLen];
    logic [pixelWord-1:0] tableColor [tableLen];

    int unsigned lcgState = 32'd24920;

    always #20 clk_in = ~clk_in;

    matrixTop #(
        .panelWidth(panelWidth)
    ) matrixTop_inst (
        .clk_in,
        .reset,
        .wrEn,
        .wrX,
        .wrY,
        .wrColor,
        .brightWrEn,
        .brightValue,
        .rgb1,
        .rgb2,
        .rowAddr,
        .latch,
        .panelOe,
        .pixClk,
        .initDone
    );

    matrixChecker #(
        .panelWidth(panelWidth)
    ) checker_inst (
        .clk_in,
        .reset,
        .wrEn,
        .wrX,
        .wrY,
        .wrColor,
        .rgb1,
        .rgb2,
        .rowAddr,
        .latch,
        .panelOe,
        .pixClk,
        .initDone,
        .arm,
        .windowBase,
        .initPixels,
        .frameCount,
        .checkCount,
        .windowChecks,
        .initErrors,
        .doneErrors,
        .dataErrors,
        .orderErrors,
        .windowErrors
    );

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 8;
    endfunction

    // all drive tasks start and end 1 ns after a rising edge
    task automatic writePixel(input logic [xBits-1:0] x, input logic [yBits-1:0] y,
                              input logic [pixelWord-1:0] color);
        wrEn    = 1'b1;
        wrX     = x;
        wrY     = y;
        wrColor = color;
        @(posedge clk_in);
        #1;
        wrEn = 1'b0;
    endtask

    task automatic setBrightness(input logic [colorBits-1:0] value);
        brightWrEn  = 1'b1;
        brightValue = value;
        @(posedge clk_in);
        #1;
        brightWrEn = 1'b0;
    endtask

    task automatic waitInitDone(output logic timedOut);
        int cycles;
        cycles   = 0;
        timedOut = 1'b0;
        while (!initDone && cycles < initLimit) begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (!initDone) begin
            $display("timeout: initDone did not rise within %0d cycles", initLimit);
            timedOut = 1'b1;
        end
    endtask

    // the first counted frame may be partial, so callers ask for two
    task automatic waitFrames(input int frames, output logic timedOut);
        int target;
        int cycles;
        target   = frameCount + frames;
        cycles   = 0;
        timedOut = 1'b0;
        while (frameCount < target && cycles < frames * frameLimit) begin
            @(posedge clk_in);
            #1;
            cycles++;
        end
        if (frameCount < target) begin
            $display("timeout: scan did not finish %0d frames in %0d cycles", frames, cycles);
            timedOut = 1'b1;
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errors);
        $display("test %0d %s: %s, %0d errors", num, name, (errors == 0) ? "ok" : "FAILED",
                 errors);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    // stops early on a timeout, the caller reports the result
    task automatic runTests(output logic timedOut);
        int dataBefore;
        int orderBefore;
        int windowBefore;
        int checksBefore;
        int missing;
        waitInitDone(timedOut);
        if (timedOut) begin
            return;
        end

        // configuration stream and completion
        if (initPixels != 2 * panelWidth) begin
            $display("error at %0t: initPixels expected %0d got %0d", $time,
                     2 * panelWidth, initPixels);
            tbErrors++;
        end
        reportTest(1, "init stream", initErrors + tbErrors);

        // whole frame gets a known value, address mixed into the LCG
        for (int y = 0; y < panelRows; y++) begin
            for (int x = 0; x < panelWidth; x++) begin
                writePixel(xBits'(x), yBits'(y),
                           pixelWord'(nextRand() ^ 32'(y * panelWidth + x)));
            end
        end
        reportTest(2, "init completion", doneErrors);

        // table entries, checker idle while the frame changes
        dataBefore   = dataErrors;
        orderBefore  = orderErrors;
        windowBefore = windowErrors;
        missing      = 0;
        for (int i = 0; i < tableLen; i++) begin
            arm = 1'b0;
            writePixel(tableX[i], tableY[i], tableColor[i]);
            setBrightness(tableBright[i]);
            windowBase   = tableWindow[i];
            arm          = 1'b1;
            checksBefore = windowChecks;
            waitFrames(2, timedOut);
            if (timedOut) begin
                return;
            end
            if (windowChecks == checksBefore) begin
                $display("no output-enable window was measured for brightness %0d",
                         tableBright[i]);
                missing++;
            end
        end
        tbErrors += missing;
        reportTest(3, "shifted frame data", dataErrors - dataBefore);
        reportTest(4, "row and plane order", orderErrors - orderBefore);
        reportTest(5, "brightness windows", windowErrors - windowBefore + missing);

        // inverted colour on one pixel, rest of the frame as before
        dataBefore = dataErrors;
        arm        = 1'b0;
        writePixel(tableX[tableLen-1], tableY[tableLen-1], ~tableColor[tableLen-1]);
        arm = 1'b1;
        waitFrames(2, timedOut);
        if (timedOut) begin
            return;
        end
        reportTest(6, "overwrite", dataErrors - dataBefore);
    endtask

    initial begin
        logic timedOut;
        int   total;
        reset       = 1'b1;
        wrEn        = 1'b0;
        wrX         = '0;
        wrY         = '0;
        wrColor     = '0;
        brightWrEn  = 1'b0;
        brightValue = '0;
        arm         = 1'b0;
        windowBase  = 16;
        tbErrors    = 0;
        for (int i = 0; i < tableLen; i++) begin
            tableX[i]     = xBits'(nextRand());
            tableY[i]     = yBits'(nextRand());
            tableColor[i] = pixelWord'(nextRand());
        end
        repeat (10) @(posedge clk_in);
        #1;
        reset = 1'b0;

        runTests(timedOut);

        total = initErrors + doneErrors + dataErrors + orderErrors + windowErrors + tbErrors;
        $display("%0d checks, %0d errors", checkCount, total);
        if (!timedOut && total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
